// File: design/isa_pkg.sv
package isa_pkg;

    // --------------------
    // Opcodes
    // --------------------
    localparam logic [2:0] OP_ADD  = 3'd0;
    localparam logic [2:0] OP_ADDI = 3'd1;
    localparam logic [2:0] OP_NAND = 3'd2;
    localparam logic [2:0] OP_LUI  = 3'd3;
    localparam logic [2:0] OP_SW   = 3'd4;
    localparam logic [2:0] OP_LW   = 3'd5;

    // --------------------
    // Instruction fields
    // --------------------
    // Top bit of each field
    localparam int OPCODE_MSB = 15;
    localparam int REGA_MSB   = 12;
    localparam int REGB_MSB   = 9;
    localparam int REGC_MSB   = 2;

    // Signed short immediate in the low bits
    localparam int SIMM_WIDTH = 7;
    // LUI immediate lands in the upper bits of the word
    localparam int LIMM_WIDTH = 10;

endpackage

// File: design/core_pkg.sv
package core_pkg;

    // --------------------
    // Datapath sizes
    // --------------------
    localparam int WORD_WIDTH = 16;
    localparam int REG_COUNT  = 8;

    // Data and instruction word
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Register number and opcode holder
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
    typedef logic [2:0] opcode_t;

    // ALU function select
    typedef enum logic {
        ALU_ADD,
        ALU_NAND
    } alu_op_t;

    localparam word_t RESET_PC = '0;

endpackage

// File: design/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_stall,
    input  core_pkg::word_t i_inst,
    output core_pkg::word_t o_pc,
    output logic            o_valid,
    output core_pkg::word_t o_instr
);

    core_pkg::word_t pc;

    // Instruction memory is read combinationally at this address
    assign o_pc = pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc      <= core_pkg::RESET_PC;
            o_valid <= 1'b0;
            o_instr <= '0;
        end else if (!i_stall) begin
            pc      <= pc + core_pkg::word_t'(1);
            o_valid <= 1'b1;
            o_instr <= i_inst;
        end
        // Load-use stall keeps PC and the fetched word
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                i_clk,
    input  core_pkg::reg_addr_t i_rd_addr1,
    input  core_pkg::reg_addr_t i_rd_addr2,
    output core_pkg::word_t     o_rd_data1,
    output core_pkg::word_t     o_rd_data2,
    input  logic                i_wr_en,
    input  core_pkg::reg_addr_t i_wr_addr,
    input  core_pkg::word_t     i_wr_data
);

    core_pkg::word_t regs [core_pkg::REG_COUNT];

    // Register 0 is never written
    always_ff @(posedge i_clk) begin
        if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Asynchronous reads, r0 forced to zero
    assign o_rd_data1 = (i_rd_addr1 == '0) ? '0 : regs[i_rd_addr1];
    assign o_rd_data2 = (i_rd_addr2 == '0) ? '0 : regs[i_rd_addr2];

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_stall,
    input  logic                i_valid,
    input  core_pkg::word_t     i_instr,
    input  logic                i_wr_en,
    input  core_pkg::reg_addr_t i_wr_addr,
    input  core_pkg::word_t     i_wr_data,
    input  core_pkg::reg_addr_t i_wb_tgt,
    input  core_pkg::word_t     i_wb_result,
    output logic                o_valid,
    output core_pkg::opcode_t   o_opcode,
    output core_pkg::reg_addr_t o_src1,
    output core_pkg::reg_addr_t o_src2,
    output core_pkg::reg_addr_t o_tgt,
    output core_pkg::word_t     o_operand1,
    output core_pkg::word_t     o_operand2,
    output core_pkg::word_t     o_imm
);

    localparam int REG_W = $bits(core_pkg::reg_addr_t);
    localparam int OPC_W = $bits(core_pkg::opcode_t);
    localparam int SIMM_PAD = core_pkg::WORD_WIDTH - isa_pkg::SIMM_WIDTH;
    localparam int LIMM_PAD = core_pkg::WORD_WIDTH - isa_pkg::LIMM_WIDTH;

    core_pkg::opcode_t   opcode;
    core_pkg::reg_addr_t reg_a;
    core_pkg::reg_addr_t reg_b;
    core_pkg::reg_addr_t reg_c;
    core_pkg::word_t     simm_ext;
    core_pkg::word_t     limm_ext;
    core_pkg::reg_addr_t src1;
    core_pkg::reg_addr_t src2;
    core_pkg::reg_addr_t tgt;
    core_pkg::word_t     imm;
    core_pkg::word_t     rd_data1;
    core_pkg::word_t     rd_data2;

    // --------------------
    // Field split
    // --------------------
    assign opcode = i_instr[isa_pkg::OPCODE_MSB -: OPC_W];
    assign reg_a  = i_instr[isa_pkg::REGA_MSB -: REG_W];
    assign reg_b  = i_instr[isa_pkg::REGB_MSB -: REG_W];
    assign reg_c  = i_instr[isa_pkg::REGC_MSB -: REG_W];

    assign simm_ext = {{SIMM_PAD{i_instr[isa_pkg::SIMM_WIDTH-1]}},
                       i_instr[isa_pkg::SIMM_WIDTH-1:0]};
    assign limm_ext = {i_instr[isa_pkg::LIMM_WIDTH-1:0], {LIMM_PAD{1'b0}}};

    // Sources and target per opcode
    always_comb begin
        tgt  = reg_a;
        src1 = reg_b;
        src2 = '0;
        imm  = simm_ext;
        case (opcode)
            isa_pkg::OP_ADD, isa_pkg::OP_NAND: begin
                src2 = reg_c;
                imm  = '0;
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_LW: begin
            end
            isa_pkg::OP_LUI: begin
                src1 = '0;
                imm  = limm_ext;
            end
            // Store data comes from regA, nothing written back
            isa_pkg::OP_SW: begin
                tgt  = '0;
                src2 = reg_a;
            end
            default: begin
                tgt  = '0;
                src1 = '0;
                imm  = '0;
            end
        endcase
    end

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rd_addr1 (src1),
        .i_rd_addr2 (src2),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2),
        .i_wr_en    (i_wr_en),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data)
    );

    // --------------------
    // Decode register
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid    <= 1'b0;
            o_opcode   <= isa_pkg::OP_ADD;
            o_src1     <= '0;
            o_src2     <= '0;
            o_tgt      <= '0;
            o_operand1 <= '0;
            o_operand2 <= '0;
            o_imm      <= '0;
        end else if (i_stall) begin
            // Held operands pick up the value leaving writeback
            if ((o_src1 != '0) && (o_src1 == i_wb_tgt)) begin
                o_operand1 <= i_wb_result;
            end
            if ((o_src2 != '0) && (o_src2 == i_wb_tgt)) begin
                o_operand2 <= i_wb_result;
            end
        end else begin
            o_valid    <= i_valid;
            o_opcode   <= opcode;
            o_src1     <= src1;
            o_src2     <= src2;
            o_tgt      <= tgt;
            o_operand1 <= rd_data1;
            o_operand2 <= rd_data2;
            o_imm      <= imm;
        end
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  core_pkg::opcode_t   i_opcode,
    input  core_pkg::reg_addr_t i_src1,
    input  core_pkg::reg_addr_t i_src2,
    input  core_pkg::reg_addr_t i_tgt,
    input  core_pkg::word_t     i_operand1,
    input  core_pkg::word_t     i_operand2,
    input  core_pkg::word_t     i_imm,
    input  core_pkg::reg_addr_t i_mem_tgt,
    input  core_pkg::word_t     i_mem_result,
    input  core_pkg::reg_addr_t i_wb_tgt,
    input  core_pkg::word_t     i_wb_result,
    output logic                o_stall,
    output logic                o_valid,
    output core_pkg::opcode_t   o_opcode,
    output core_pkg::reg_addr_t o_tgt,
    output core_pkg::word_t     o_result,
    output core_pkg::word_t     o_store_data
);

    core_pkg::word_t   fwd1;
    core_pkg::word_t   fwd2;
    core_pkg::word_t   alu_a;
    core_pkg::word_t   alu_b;
    core_pkg::word_t   alu_out;
    core_pkg::alu_op_t alu_op;

    // Youngest producer wins
    function automatic core_pkg::word_t forward(
        input core_pkg::reg_addr_t src,
        input core_pkg::word_t     rf_value
    );
        if (src == '0) begin
            return '0;
        end else if (src == o_tgt) begin
            return o_result;
        end else if (src == i_mem_tgt) begin
            return i_mem_result;
        end else if (src == i_wb_tgt) begin
            return i_wb_result;
        end
        return rf_value;
    endfunction

    // --------------------
    // Operand select
    // --------------------
    always_comb begin
        fwd1 = forward(i_src1, i_operand1);
        fwd2 = forward(i_src2, i_operand2);
    end

    always_comb begin
        alu_a = fwd1;
        case (i_opcode)
            isa_pkg::OP_ADDI, isa_pkg::OP_LUI,
            isa_pkg::OP_SW, isa_pkg::OP_LW: alu_b = i_imm;
            default:                        alu_b = fwd2;
        endcase
        alu_op = (i_opcode == isa_pkg::OP_NAND) ? core_pkg::ALU_NAND : core_pkg::ALU_ADD;
    end

    always_comb begin
        case (alu_op)
            core_pkg::ALU_NAND: alu_out = ~(alu_a & alu_b);
            default:            alu_out = alu_a + alu_b;
        endcase
    end

    // Load data not ready until the memory stage
    assign o_stall = (o_opcode == isa_pkg::OP_LW) && (o_tgt != '0) &&
                     ((o_tgt == i_src1) || (o_tgt == i_src2));

    // --------------------
    // Execute register
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst || o_stall) begin
            // Bubble behind the load
            o_valid      <= 1'b0;
            o_opcode     <= isa_pkg::OP_ADD;
            o_tgt        <= '0;
            o_result     <= '0;
            o_store_data <= '0;
        end else begin
            o_valid      <= i_valid;
            o_opcode     <= i_opcode;
            o_tgt        <= i_tgt;
            o_result     <= alu_out;
            o_store_data <= fwd2;
        end
    end

endmodule

// File: design/memory_writeback_stage.sv
`timescale 1ns/100ps

module memory_writeback_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  core_pkg::opcode_t   i_opcode,
    input  core_pkg::reg_addr_t i_tgt,
    input  core_pkg::word_t     i_result,
    input  core_pkg::word_t     i_store_data,
    input  core_pkg::word_t     i_mem_rd_data,
    output core_pkg::word_t     o_mem_addr,
    output core_pkg::word_t     o_mem_wr_data,
    output logic                o_mem_wr_en,
    output logic                o_mem_valid,
    output core_pkg::reg_addr_t o_mem_tgt,
    output core_pkg::word_t     o_mem_result,
    output core_pkg::reg_addr_t o_wb_tgt,
    output core_pkg::word_t     o_wb_result
);

    logic            mem_is_load;
    core_pkg::word_t mem_alu_result;

    // Data memory port straight from the execute register
    assign o_mem_addr    = i_result;
    assign o_mem_wr_data = i_store_data;
    assign o_mem_wr_en   = i_valid && (i_opcode == isa_pkg::OP_SW);

    // --------------------
    // Memory register
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mem_valid    <= 1'b0;
            mem_is_load    <= 1'b0;
            o_mem_tgt      <= '0;
            mem_alu_result <= '0;
        end else begin
            o_mem_valid    <= i_valid;
            mem_is_load    <= (i_opcode == isa_pkg::OP_LW);
            o_mem_tgt      <= i_tgt;
            mem_alu_result <= i_result;
        end
    end

    // Read data arrives one cycle after the address
    assign o_mem_result = mem_is_load ? i_mem_rd_data : mem_alu_result;

    // Writeback copy for late forwarding
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_tgt    <= '0;
            o_wb_result <= '0;
        end else begin
            o_wb_tgt    <= o_mem_tgt;
            o_wb_result <= o_mem_result;
        end
    end

endmodule

// File: design/risc16_core.sv
`timescale 1ns/100ps

module risc16_core (
    input  logic            i_clk,
    input  logic            i_rst,
    input  core_pkg::word_t i_inst,
    output core_pkg::word_t o_pc,
    input  core_pkg::word_t i_mem_rd_data,
    output core_pkg::word_t o_mem_addr,
    output core_pkg::word_t o_mem_wr_data,
    output logic            o_mem_wr_en
);

    logic                stall;

    // Fetch to decode
    logic                f_valid;
    core_pkg::word_t     f_instr;

    // Decode to execute
    logic                d_valid;
    core_pkg::opcode_t   d_opcode;
    core_pkg::reg_addr_t d_src1;
    core_pkg::reg_addr_t d_src2;
    core_pkg::reg_addr_t d_tgt;
    core_pkg::word_t     d_operand1;
    core_pkg::word_t     d_operand2;
    core_pkg::word_t     d_imm;

    // Execute to memory
    logic                e_valid;
    core_pkg::opcode_t   e_opcode;
    core_pkg::reg_addr_t e_tgt;
    core_pkg::word_t     e_result;
    core_pkg::word_t     e_store_data;

    // Memory and writeback results, fed back
    logic                m_valid;
    core_pkg::reg_addr_t m_tgt;
    core_pkg::word_t     m_result;
    core_pkg::reg_addr_t w_tgt;
    core_pkg::word_t     w_result;

    fetch_stage u_fetch_stage (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (stall),
        .i_inst  (i_inst),
        .o_pc    (o_pc),
        .o_valid (f_valid),
        .o_instr (f_instr)
    );

    decode_stage u_decode_stage (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_stall     (stall),
        .i_valid     (f_valid),
        .i_instr     (f_instr),
        .i_wr_en     (m_valid),
        .i_wr_addr   (m_tgt),
        .i_wr_data   (m_result),
        .i_wb_tgt    (w_tgt),
        .i_wb_result (w_result),
        .o_valid     (d_valid),
        .o_opcode    (d_opcode),
        .o_src1      (d_src1),
        .o_src2      (d_src2),
        .o_tgt       (d_tgt),
        .o_operand1  (d_operand1),
        .o_operand2  (d_operand2),
        .o_imm       (d_imm)
    );

    execute_stage u_execute_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (d_valid),
        .i_opcode     (d_opcode),
        .i_src1       (d_src1),
        .i_src2       (d_src2),
        .i_tgt        (d_tgt),
        .i_operand1   (d_operand1),
        .i_operand2   (d_operand2),
        .i_imm        (d_imm),
        .i_mem_tgt    (m_tgt),
        .i_mem_result (m_result),
        .i_wb_tgt     (w_tgt),
        .i_wb_result  (w_result),
        .o_stall      (stall),
        .o_valid      (e_valid),
        .o_opcode     (e_opcode),
        .o_tgt        (e_tgt),
        .o_result     (e_result),
        .o_store_data (e_store_data)
    );

    memory_writeback_stage u_memory_writeback_stage (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_valid       (e_valid),
        .i_opcode      (e_opcode),
        .i_tgt         (e_tgt),
        .i_result      (e_result),
        .i_store_data  (e_store_data),
        .i_mem_rd_data (i_mem_rd_data),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en),
        .o_mem_valid   (m_valid),
        .o_mem_tgt     (m_tgt),
        .o_mem_result  (m_result),
        .o_wb_tgt      (w_tgt),
        .o_wb_result   (w_result)
    );

endmodule

// File: testbench/core_tb.sv
`timescale 1ns/100ps

module core_tb;

    localparam int BODY_LEN   = 200;
    localparam int IMEM_DEPTH = 1024;
    localparam int DMEM_DEPTH = 128;
    localparam int EPI_ADDR   = 48;

    logic            i_clk;
    logic            i_rst;
    core_pkg::word_t i_inst;
    core_pkg::word_t o_pc;
    core_pkg::word_t i_mem_rd_data;
    core_pkg::word_t o_mem_addr;
    core_pkg::word_t o_mem_wr_data;
    logic            o_mem_wr_en;

    core_pkg::word_t imem [IMEM_DEPTH];
    core_pkg::word_t dmem [DMEM_DEPTH];
    core_pkg::word_t rd_q;

    integer          seed = 32'ha055_a5f8;
    int              prog_len;
    int              load_use_pairs;
    int              checks;
    int              fails [1:6];
    core_pkg::word_t exp_addr [$];
    core_pkg::word_t exp_data [$];

    risc16_core u_risc16_core (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_inst        (i_inst),
        .o_pc          (o_pc),
        .i_mem_rd_data (i_mem_rd_data),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    // --------------------
    // Memories
    // --------------------
    // Fetch word and load data both change mid-cycle
    always @(negedge i_clk) begin
        i_inst        <= imem[o_pc[9:0]];
        i_mem_rd_data <= rd_q;
    end

    always @(posedge i_clk) begin
        if (o_mem_wr_en) begin
            dmem[o_mem_addr[6:0]] <= o_mem_wr_data;
        end
        rd_q <= dmem[o_mem_addr[6:0]];
    end

    function automatic core_pkg::word_t fill_word(input core_pkg::word_t addr);
        return (addr * 16'h2f1d) ^ {addr[7:0], addr[15:8]} ^ 16'hc3a5;
    endfunction

    // Instruction formats
    function automatic core_pkg::word_t rrr_word(input logic [2:0] op, input logic [2:0] a,
                                                 input logic [2:0] b, input logic [2:0] c);
        return {op, a, b, 4'b0000, c};
    endfunction

    function automatic core_pkg::word_t rri_word(input logic [2:0] op, input logic [2:0] a,
                                                 input logic [2:0] b, input logic [6:0] imm);
        return {op, a, b, imm};
    endfunction

    function automatic core_pkg::word_t lui_word(input logic [2:0] a, input logic [9:0] imm);
        return {isa_pkg::OP_LUI, a, imm};
    endfunction

    task automatic append_instr(input core_pkg::word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // --------------------
    // Program
    // --------------------
    task automatic build_program;
        logic [31:0] r;
        logic [2:0]  op;
        int          k;
        // Every register gets a defined value first
        for (k = 1; k < 8; k++) begin
            r = $random(seed);
            append_instr(rri_word(isa_pkg::OP_ADDI, k[2:0], 3'd0, r[6:0]));
        end
        while (prog_len < BODY_LEN) begin
            r  = $random(seed);
            op = r[31:27] % 6;
            if ((op == isa_pkg::OP_LW || op == isa_pkg::OP_SW) && prog_len > BODY_LEN - 2) begin
                op = isa_pkg::OP_ADDI;
            end
            case (op)
                isa_pkg::OP_ADD, isa_pkg::OP_NAND:
                    append_instr(rrr_word(op, r[18:16], r[21:19], r[24:22]));
                isa_pkg::OP_ADDI:
                    append_instr(rri_word(op, r[18:16], r[21:19], r[6:0]));
                isa_pkg::OP_LUI:
                    append_instr(lui_word(r[18:16], r[9:0]));
                default: begin
                    // Base register seeded so the address stays below 128
                    append_instr(rri_word(isa_pkg::OP_ADDI, r[21:19], 3'd0, {1'b0, r[5:0]}));
                    append_instr(rri_word(op, r[18:16], r[21:19], {1'b0, r[11:6]}));
                end
            endcase
        end
        // Dependent chain, back to back
        append_instr(lui_word(3'd1, 10'h2ab));
        append_instr(rri_word(isa_pkg::OP_ADDI, 3'd1, 3'd1, 7'h05));
        append_instr(rrr_word(isa_pkg::OP_ADD, 3'd2, 3'd1, 3'd1));
        append_instr(rrr_word(isa_pkg::OP_NAND, 3'd3, 3'd2, 3'd1));
        append_instr(rrr_word(isa_pkg::OP_ADD, 3'd4, 3'd3, 3'd2));
        append_instr(rri_word(isa_pkg::OP_ADDI, 3'd5, 3'd4, 7'h79));
        append_instr(lui_word(3'd6, 10'h155));
        append_instr(rrr_word(isa_pkg::OP_NAND, 3'd6, 3'd6, 3'd5));
        // Load-use pairs
        append_instr(rri_word(isa_pkg::OP_SW, 3'd5, 3'd0, 7'd40));
        append_instr(rri_word(isa_pkg::OP_LW, 3'd7, 3'd0, 7'd40));
        append_instr(rrr_word(isa_pkg::OP_ADD, 3'd7, 3'd7, 3'd6));
        append_instr(rri_word(isa_pkg::OP_LW, 3'd2, 3'd0, 7'd41));
        append_instr(rri_word(isa_pkg::OP_SW, 3'd2, 3'd0, 7'd42));
        append_instr(rri_word(isa_pkg::OP_LW, 3'd3, 3'd0, 7'd42));
        append_instr(rrr_word(isa_pkg::OP_NAND, 3'd3, 3'd3, 3'd3));
        // Writes aimed at r0
        append_instr(rri_word(isa_pkg::OP_ADDI, 3'd0, 3'd5, 7'h11));
        append_instr(lui_word(3'd0, 10'h3ff));
        append_instr(rri_word(isa_pkg::OP_LW, 3'd0, 3'd0, 7'd40));
        append_instr(rrr_word(isa_pkg::OP_ADD, 3'd1, 3'd0, 3'd4));
        // Epilogue dumps r0 to r7
        for (k = 0; k < 8; k++) begin
            append_instr(rri_word(isa_pkg::OP_SW, k[2:0], 3'd0, 7'(EPI_ADDR + k)));
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    task automatic run_model;
        core_pkg::word_t regs [8];
        core_pkg::word_t mem [DMEM_DEPTH];
        core_pkg::word_t w;
        core_pkg::word_t addr;
        logic [2:0]      op;
        logic [2:0]      a;
        logic [2:0]      b;
        logic [2:0]      c;
        logic [2:0]      prev_op;
        logic [2:0]      prev_a;
        logic            reads_prev;
        int              i;
        for (i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < DMEM_DEPTH; i++) begin
            mem[i] = fill_word(i[15:0]);
        end
        prev_op = isa_pkg::OP_ADD;
        prev_a  = '0;
        for (i = 0; i < prog_len; i++) begin
            w    = imem[i];
            op   = w[15:13];
            a    = w[12:10];
            b    = w[9:7];
            c    = w[2:0];
            addr = regs[b] + {{9{w[6]}}, w[6:0]};
            // Next instruction reads what the load writes
            reads_prev = ((b == prev_a) && (op != isa_pkg::OP_LUI)) ||
                         ((c == prev_a) && (op == isa_pkg::OP_ADD || op == isa_pkg::OP_NAND)) ||
                         ((a == prev_a) && (op == isa_pkg::OP_SW));
            if (prev_op == isa_pkg::OP_LW && prev_a != '0 && reads_prev) begin
                load_use_pairs++;
            end
            case (op)
                isa_pkg::OP_ADD:  regs[a] = regs[b] + regs[c];
                isa_pkg::OP_ADDI: regs[a] = addr;
                isa_pkg::OP_NAND: regs[a] = ~(regs[b] & regs[c]);
                isa_pkg::OP_LUI:  regs[a] = {w[9:0], 6'b000000};
                isa_pkg::OP_LW:   regs[a] = mem[addr[6:0]];
                default: begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[a]);
                    mem[addr[6:0]] = regs[a];
                end
            endcase
            regs[0] = '0;
            prev_op = op;
            prev_a  = a;
        end
    endtask

    task automatic compare_word(input int test_id, input string name,
                                input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            fails[test_id]++;
        end
    endtask

    task automatic report_test(input int test_id, input string title);
        if (fails[test_id] == 0) begin
            $display("Test %0d %s: PASS", test_id, title);
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", test_id, title, fails[test_id]);
        end
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        int              i;
        int              cycles;
        int              limit;
        int              store_idx;
        int              epi_first;
        int              stall_cycles;
        int              total;
        core_pkg::word_t prev_pc;
        i_rst         = 1'b1;
        i_inst        = '0;
        i_mem_rd_data = '0;
        rd_q          = '0;
        prog_len      = 0;
        checks        = 0;
        for (i = 1; i <= 6; i++) begin
            fails[i] = 0;
        end
        for (i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = '0;
        end
        for (i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = fill_word(i[15:0]);
        end
        load_use_pairs = 0;
        build_program();
        run_model();
        limit     = prog_len * 2 + 100;
        epi_first = exp_addr.size() - 8;

        repeat (10) begin
            @(negedge i_clk);
            compare_word(1, "o_pc", o_pc, core_pkg::RESET_PC);
            compare_word(1, "o_mem_wr_en", o_mem_wr_en, 0);
        end
        i_rst <= 1'b0;
        #1;
        compare_word(1, "o_pc", o_pc, core_pkg::RESET_PC);
        compare_word(1, "o_mem_wr_en", o_mem_wr_en, 0);
        report_test(1, "reset");

        prev_pc      = o_pc;
        store_idx    = 0;
        cycles       = 0;
        stall_cycles = 0;
        while (store_idx < exp_addr.size() && cycles < limit) begin
            @(negedge i_clk);
            cycles++;
            if (o_pc == prev_pc) begin
                stall_cycles++;
            end else begin
                compare_word(4, "o_pc", o_pc, prev_pc + 16'd1);
            end
            prev_pc = o_pc;
            if (o_mem_wr_en) begin
                compare_word(2, "o_mem_addr", o_mem_addr, exp_addr[store_idx]);
                if (store_idx < epi_first) begin
                    compare_word(2, "o_mem_wr_data", o_mem_wr_data, exp_data[store_idx]);
                end else if (store_idx == epi_first) begin
                    compare_word(5, "o_mem_wr_data", o_mem_wr_data, exp_data[store_idx]);
                end else begin
                    compare_word(3, "o_mem_wr_data", o_mem_wr_data, exp_data[store_idx]);
                end
                store_idx++;
            end
        end

        report_test(2, "store stream");
        report_test(3, "forwarding");
        compare_word(4, "load-use stall count", stall_cycles, load_use_pairs);
        report_test(4, "load-use stall");
        report_test(5, "register 0");
        checks++;
        assert (store_idx == exp_addr.size()) else begin
            $display("Run timed out after %0d cycles, only %0d of %0d stores were seen",
                     cycles, store_idx, exp_addr.size());
            fails[6]++;
        end
        report_test(6, "completion");

        total = 0;
        for (i = 1; i <= 6; i++) begin
            total += fails[i];
        end
        $display("Checks run: %0d, failed: %0d", checks, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src.f
design/isa_pkg.sv
design/core_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_writeback_stage.sv
design/risc16_core.sv
testbench/core_tb.sv
